//--- spiBridge.f
+incdir+common
+incdir+sim
common/spiBridgePkg.sv
spiSlave/spiSlaveFrontEnd.sv
spiSlave/spiFrameDecoder.sv
verilog/csrBank.sv
verilog/spiBridgeTop.sv
sim/spiBridgeTb.sv

//--- Bender.yml
package:
  name: spiBridge

export_include_dirs:
  - common

sources:
  # Package first, then the blocks, top level last
  - include_dirs:
      - common
    files:
      - common/spiBridgePkg.sv
      - spiSlave/spiSlaveFrontEnd.sv
      - spiSlave/spiFrameDecoder.sv
      - verilog/csrBank.sv
      - verilog/spiBridgeTop.sv

  - target: simulation
    include_dirs:
      - common
      - sim
    files:
      - sim/spiBridgeTb.sv

//--- sim/spiMasterTasks.svh
// SPI mode 0 master for the testbench; fixed SCK half period, needs the testbench pins and counters
`ifndef SPIMASTERTASKS_SVH
`define SPIMASTERTASKS_SVH

// ------------------------------
// Pin level
// ------------------------------
// Ends 1 unit past a rising edge
task automatic waitClocks(input int n);
	repeat (n) @(posedge iSysClk);
	#1;
endtask

// MSB first, MISO taken just before each rising edge
task automatic shiftBits(input spiByte_t mosiByte, input int nBits, output spiByte_t misoByte);
	misoByte = '1;
	for (int i = 7; i > 7 - nBits; i--)
	begin
		spiMosi = mosiByte[i];
		waitClocks(`SCK_HALF_MIN);
		misoByte[i] = spiMiso;
		spiSck = 1'b1;
		waitClocks(`SCK_HALF_MIN);
		spiSck = 1'b0;
	end
endtask

// ------------------------------
// Frame level
// ------------------------------
// Chip select low, then address, command, length and dummy
task automatic sendHeader(input csrAddr_t addr, input spiByte_t cmd, input logic [15:0] len);
	spiByte_t hdr [`HDR_BYTES];
	spiByte_t rx;
	hdr = '{addr[31:24], addr[23:16], addr[15:8], addr[7:0], cmd, len[15:8], len[7:0], 8'h00};
	spiCsN = 1'b0;
	waitClocks(`SCK_HALF_MIN);
	foreach (hdr[i])
		shiftBits(hdr[i], 8, rx);
endtask

// Full frame, data phase MISO bytes packed MSB first
task automatic runFrame(input csrAddr_t addr, input spiByte_t cmd, input logic [15:0] len,
	input csrData_t wrData, output csrData_t rdData);
	spiByte_t rx;
	sendHeader(addr, cmd, len);
	for (int i = 0; i < `DATA_BYTES; i++)
	begin
		shiftBits(wrData[31 - 8*i -: 8], 8, rx);
		rdData[31 - 8*i -: 8] = rx;
	end
	waitClocks(`SCK_HALF_MIN);
	spiCsN = 1'b1;
	// Gap between frames
	waitClocks(16);
endtask

// Write frame cut off in the middle of its data
task automatic abortWrite(input csrAddr_t addr, input csrData_t wrData);
	spiByte_t rx;
	sendHeader(addr, CmdCsrWrite, 16'(`DATA_BYTES));
	for (int i = 0; i < `DATA_BYTES / 2; i++)
		shiftBits(wrData[31 - 8*i -: 8], 8, rx);
	// Half a byte more, then chip select high
	shiftBits(wrData[15:8], 4, rx);
	waitClocks(`SCK_HALF_MIN);
	spiCsN = 1'b1;
	waitClocks(16);
endtask

// ------------------------------
// Compare
// ------------------------------
task automatic checkWord(input string name, input csrData_t expected, input csrData_t actual);
	checkCount++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
	end
endtask

task automatic checkByte(input string name, input spiByte_t expected, input spiByte_t actual);
	checkCount++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
	end
endtask

task automatic checkBit(input string name, input logic expected, input logic actual);
	checkCount++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
	end
endtask

`endif

//--- sim/spiBridgeTb.sv
// Register model starts unknown except register 0, so every index is written before random reads
`include "spiBridge_consts.svh"

module spiBridgeTb import spiBridgePkg::*;
();

	localparam int clkPeriod = 10;
	localparam int randomOps = 200;
	// Directed frames on top of the random ones
	localparam int frameBudget = randomOps + 120;
	// Serial bits plus chip select edges and the gap
	localparam int frameCycles = (`HDR_BYTES + `DATA_BYTES) * 16 * `SCK_HALF_MIN + 32;

	logic     iSysClk;
	logic     rst;
	logic     spiSck;
	logic     spiCsN;
	logic     spiMosi;
	logic     spiMiso;
	int       errorCount;
	int       checkCount;
	// Reference copy of the bank
	csrData_t model [`CSR_COUNT];

	`include "spiMasterTasks.svh"

	spiBridgeTop uut (
		.iSysClk (iSysClk),
		.rst     (rst),
		.spiSck  (spiSck),
		.spiCsN  (spiCsN),
		.spiMosi (spiMosi),
		.spiMiso (spiMiso)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #(clkPeriod / 2) iSysClk = ~iSysClk;
	end

	// Watchdog
	initial
	begin
		#(frameBudget * frameCycles * 2 * clkPeriod);
		$display("Timeout: test sequence did not finish within %0d frame times", frameBudget);
		$display("Verification failed");
		$finish;
	end

	// ------------------------------
	// Reference model
	// ------------------------------
	// Index is byte address bits 5:2, 64 and up is out of range
	function automatic csrData_t expectRead(input csrAddr_t addr);
		if (addr >= 64)
			return '0;
		if (addr[5:2] == 4'd0)
			return `CSR_ID_VALUE;
		return model[addr[5:2]];
	endfunction

	function automatic void modelWrite(input csrAddr_t addr, input csrData_t data);
		if (addr < 64 && addr[5:2] != 4'd0)
			model[addr[5:2]] = data;
	endfunction

	// ------------------------------
	// Access helpers
	// ------------------------------
	task automatic writeReg(input csrAddr_t addr, input csrData_t data);
		csrData_t rd;
		runFrame(addr, CmdCsrWrite, 16'(`DATA_BYTES), data, rd);
		modelWrite(addr, data);
	endtask

	task automatic readReg(input csrAddr_t addr);
		csrData_t rd;
		runFrame(addr, CmdCsrRead, 16'(`DATA_BYTES), $urandom, rd);
		checkWord($sformatf("spiMiso word at %08h", addr), expectRead(addr), rd);
	endtask

	// Whole bank against the model
	task automatic verifyAll();
		for (int i = 0; i < `CSR_COUNT; i++)
			readReg(csrAddr_t'(i * 4));
	endtask

	// Bad command or length, MISO stays idle
	task automatic sendIgnored(input csrAddr_t addr, input spiByte_t cmd, input logic [15:0] len);
		csrData_t rd;
		runFrame(addr, cmd, len, $urandom, rd);
		for (int i = 0; i < `DATA_BYTES; i++)
			checkByte("spiMiso idle byte", `MISO_IDLE, rd[31 - 8*i -: 8]);
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		logic [3:0] idx;
		csrAddr_t   addr;
		errorCount = 0;
		checkCount = 0;
		rst        = 1'b1;
		spiSck     = 1'b0;
		spiCsN     = 1'b1;
		spiMosi    = 1'b0;
		void'($urandom(49));
		foreach (model[i])
			model[i] = '0;
		repeat (5) @(posedge iSysClk);
		#1;
		rst = 1'b0;
		waitClocks(2);

		// Idle line and identifier
		checkBit("spiMiso", 1'b1, spiMiso);
		readReg(32'h0);
		writeReg(32'h0, $urandom);
		readReg(32'h0);

		// Known value in every writable register
		for (int i = 1; i < `CSR_COUNT; i++)
			writeReg(csrAddr_t'(i * 4), $urandom);

		repeat (randomOps)
		begin
			idx = 4'($urandom_range(`CSR_COUNT - 1, 1));
			if ($urandom_range(1, 0) == 1)
				writeReg({26'd0, idx, 2'b00}, $urandom);
			else
				readReg({26'd0, idx, 2'b00});
		end
		verifyAll();

		// Out of range, 44h aliases index 1 in bits 5:2
		readReg(32'h40);
		readReg(32'hFFFF_FFFC);
		addr = 32'h40 | ($urandom & 32'hFFFF_FFFC);
		readReg(addr);
		writeReg(32'h44, $urandom);
		writeReg(32'h8000_0008, $urandom);
		verifyAll();

		// Unsupported command, wrong length
		sendIgnored(32'h4, 8'h02, 16'd4);
		sendIgnored(32'h8, 8'hA5, 16'd4);
		sendIgnored(32'hC, CmdCsrRead, 16'd3);
		sendIgnored(32'h10, CmdCsrWrite, 16'd8);
		sendIgnored(32'h14, CmdCsrWrite, 16'h0104);
		verifyAll();

		// Abort mid data, then a normal frame to the same register
		idx = 4'($urandom_range(`CSR_COUNT - 1, 1));
		abortWrite({26'd0, idx, 2'b00}, $urandom);
		readReg({26'd0, idx, 2'b00});
		writeReg({26'd0, idx, 2'b00}, $urandom);
		verifyAll();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- verilog/spiBridgeTop.sv
// SPI slave to register bridge; separate MOSI and MISO pins, no tristate and single chip select
module spiBridgeTop import spiBridgePkg::*;
(
	input  logic iSysClk,
	input  logic rst,
	input  logic spiSck,
	input  logic spiCsN,
	input  logic spiMosi,
	output logic spiMiso
);

	// ------------------------------
	// Internal links
	// ------------------------------
	spiRxByte_t  rxByte;
	spiTxByte_t  txByte;
	logic        csActive;
	axiLiteReq_t busReq;
	axiLiteRsp_t busRsp;

	// Serial side
	spiSlaveFrontEnd frontEnd (
		.iSysClk  (iSysClk),
		.rst      (rst),
		.spiSck   (spiSck),
		.spiCsN   (spiCsN),
		.spiMosi  (spiMosi),
		.rxByte   (rxByte),
		.txByte   (txByte),
		.csActive (csActive),
		.spiMiso  (spiMiso)
	);

	// Header parsing, bus master
	spiFrameDecoder decoder (
		.iSysClk  (iSysClk),
		.rst      (rst),
		.rxByte   (rxByte),
		.csActive (csActive),
		.txByte   (txByte),
		.busReq   (busReq),
		.busRsp   (busRsp)
	);

	// Register slave
	csrBank bank (
		.iSysClk (iSysClk),
		.rst     (rst),
		.busReq  (busReq),
		.busRsp  (busRsp)
	);

endmodule

//--- verilog/csrBank.sv
// AXI4-Lite slave, one outstanding access per channel; register 0 is read-only identifier
`include "spiBridge_consts.svh"

module csrBank import spiBridgePkg::*;
(
	input  logic        iSysClk,
	input  logic        rst,
	input  axiLiteReq_t busReq,
	output axiLiteRsp_t busRsp
);

	localparam int idxWidth = $clog2(`CSR_COUNT);
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	csrData_t              csrMem [`CSR_COUNT];
	logic [idxWidth-1:0]   wrIdx;
	logic [idxWidth-1:0]   rdIdx;
	logic                  wrInRange;
	logic                  rdInRange;
	logic                  wrReady;
	logic                  arReady;
	logic                  wrFire;
	logic                  rdFire;
	logic                  bValid;
	logic                  rValid;
	logic [1:0]            bResp;
	logic [1:0]            rResp;
	csrData_t              rData;

	// Word index from byte address
	assign wrIdx     = busReq.awaddr[2 +: idxWidth];
	assign rdIdx     = busReq.araddr[2 +: idxWidth];
	assign wrInRange = busReq.awaddr < csrAddr_t'(`CSR_COUNT * 4);
	assign rdInRange = busReq.araddr < csrAddr_t'(`CSR_COUNT * 4);

	assign wrFire = wrReady && busReq.awvalid && busReq.wvalid;
	assign rdFire = arReady && busReq.arvalid;

	// ------------------------------
	// Handshake control
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			wrReady <= 1'b0;
			arReady <= 1'b0;
			bValid  <= 1'b0;
			rValid  <= 1'b0;
		end
		else
		begin
			// Ready one cycle after valid, response one after that
			wrReady <= busReq.awvalid && busReq.wvalid && !wrReady && !bValid;
			arReady <= busReq.arvalid && !arReady && !rValid;
			if (wrFire)
				bValid <= 1'b1;
			else if (bValid && busReq.bready)
				bValid <= 1'b0;
			if (rdFire)
				rValid <= 1'b1;
			else if (rValid && busReq.rready)
				rValid <= 1'b0;
		end
	end

	// ------------------------------
	// Storage and response payload
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		// Register 0 and out of range writes are dropped
		if (wrFire && wrInRange && wrIdx != '0)
		begin
			for (int b = 0; b < `DATA_BYTES; b++)
			begin
				if (busReq.wstrb[b])
					csrMem[wrIdx][8*b +: 8] <= busReq.wdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (wrFire)
			bResp <= wrInRange ? respOkay : respSlvErr;
		if (rdFire)
		begin
			rResp <= rdInRange ? respOkay : respSlvErr;
			if (!rdInRange)
				rData <= '0;
			else if (rdIdx == '0)
				rData <= `CSR_ID_VALUE;
			else
				rData <= csrMem[rdIdx];
		end
	end

	always_comb
	begin
		busRsp.awready = wrReady;
		busRsp.wready  = wrReady;
		busRsp.bvalid  = bValid;
		busRsp.bresp   = bResp;
		busRsp.arready = arReady;
		busRsp.rvalid  = rValid;
		busRsp.rdata   = rData;
		busRsp.rresp   = rResp;
	end

	// No acceptance on either channel while a response is still out
	noAcceptWhilePending: assert property (@(posedge iSysClk) disable iff (rst)
		(wrFire || rdFire) |-> !(bValid || rValid));

endmodule

//--- spiSlave/spiFrameDecoder.sv
// Register access only with length `DATA_BYTES; read must finish within the dummy byte time
`include "spiBridge_consts.svh"

module spiFrameDecoder import spiBridgePkg::*;
(
	input  logic        iSysClk,
	input  logic        rst,
	input  spiRxByte_t  rxByte,
	input  logic        csActive,
	output spiTxByte_t  txByte,
	output axiLiteReq_t busReq,
	input  axiLiteRsp_t busRsp
);

	frameState_t state;
	logic [1:0]  byteCnt;
	logic        isRead;
	logic        inBus;
	// Header fields
	csrAddr_t    addrReg;
	spiCmd_t     cmdReg;
	spiByte_t    lenHi;
	logic [15:0] lenWord;
	logic        lenOk;
	logic        cmdOk;
	// Data path
	csrData_t    wrWord;
	csrData_t    rdWord;
	logic        wrValid;
	logic        arValid;
	logic        txLoad;
	spiByte_t    txData;

	assign inBus   = (state == StBusWr) || (state == StBusRd);
	assign lenWord = {lenHi, rxByte.data};
	assign lenOk   = (lenWord == 16'(`DATA_BYTES));
	assign cmdOk   = (cmdReg == CmdCsrRead) || (cmdReg == CmdCsrWrite);

	// ------------------------------
	// Frame FSM
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			state   <= StAddr;
			byteCnt <= '0;
			isRead  <= 1'b0;
			txLoad  <= 1'b0;
			wrValid <= 1'b0;
			arValid <= 1'b0;
		end
		else
		begin
			txLoad <= 1'b0;
			// Abort on chip select high, bus transfers always complete
			if (!csActive && !inBus)
			begin
				state   <= StAddr;
				byteCnt <= '0;
			end
			else
			begin
				case (state)
					StAddr:
						if (rxByte.valid)
						begin
							addrReg <= {addrReg[23:0], rxByte.data};
							byteCnt <= byteCnt + 2'd1;
							if (byteCnt == 2'd3)
								state <= StCmd;
						end
					StCmd:
						if (rxByte.valid)
						begin
							cmdReg  <= spiCmd_t'(rxByte.data);
							byteCnt <= '0;
							state   <= StLen;
						end
					StLen:
						if (rxByte.valid)
						begin
							if (byteCnt == 2'd0)
							begin
								lenHi   <= rxByte.data;
								byteCnt <= 2'd1;
							end
							else
							begin
								byteCnt <= '0;
								if (!lenOk || !cmdOk)
									state <= StIgnore;
								else if (cmdReg == CmdCsrRead)
								begin
									// Read runs while the dummy byte shifts
									isRead  <= 1'b1;
									arValid <= 1'b1;
									state   <= StBusRd;
								end
								else
								begin
									isRead <= 1'b0;
									state  <= StDummy;
								end
							end
						end
					StBusRd:
					begin
						if (arValid && busRsp.arready)
							arValid <= 1'b0;
						if (busRsp.rvalid)
						begin
							rdWord <= busRsp.rdata;
							state  <= StDummy;
						end
					end
					StDummy:
						if (rxByte.valid)
						begin
							byteCnt <= '0;
							state   <= StData;
							// First read byte follows the dummy
							if (isRead)
							begin
								txLoad <= 1'b1;
								txData <= rdWord[31:24];
								rdWord <= {rdWord[23:0], 8'h00};
							end
						end
					StData:
						if (rxByte.valid)
						begin
							byteCnt <= byteCnt + 2'd1;
							wrWord  <= {wrWord[23:0], rxByte.data};
							if (isRead && byteCnt != 2'd3)
							begin
								txLoad <= 1'b1;
								txData <= rdWord[31:24];
								rdWord <= {rdWord[23:0], 8'h00};
							end
							if (byteCnt == 2'd3)
							begin
								if (isRead)
									state <= StIgnore;
								else
								begin
									wrValid <= 1'b1;
									state   <= StBusWr;
								end
							end
						end
					StBusWr:
					begin
						// Address and data accepted together
						if (wrValid && busRsp.awready)
							wrValid <= 1'b0;
						if (busRsp.bvalid)
							state <= StIgnore;
					end
					// Wait for chip select high
					StIgnore:
						state <= StIgnore;
					default:
						state <= StAddr;
				endcase
			end
		end
	end

	// ------------------------------
	// Outputs
	// ------------------------------
	always_comb
	begin
		txByte.load    = txLoad;
		txByte.data    = txData;
		busReq.awvalid = wrValid;
		busReq.awaddr  = addrReg;
		busReq.wvalid  = wrValid;
		busReq.wdata   = wrWord;
		busReq.wstrb   = '1;
		// Response channels never stall the bank
		busReq.bready  = (state == StBusWr);
		busReq.arvalid = arValid;
		busReq.araddr  = addrReg;
		busReq.rready  = (state == StBusRd);
	end

	// Write payload held until the bank takes it
	wrPayloadStable: assert property (@(posedge iSysClk) disable iff (rst)
		(busReq.awvalid && !busRsp.awready) |=>
		($stable(busReq.awaddr) && $stable(busReq.wdata)));

	readOnlyInBusRd: assert property (@(posedge iSysClk) disable iff (rst)
		busReq.arvalid |-> (state == StBusRd));

endmodule

//--- spiSlave/spiSlaveFrontEnd.sv
// SPI mode 0 slave only; SCK half period must be at least `SCK_HALF_MIN clocks, MISO always driven
`include "spiBridge_consts.svh"

module spiSlaveFrontEnd import spiBridgePkg::*;
(
	input  logic       iSysClk,
	input  logic       rst,
	input  logic       spiSck,
	input  logic       spiCsN,
	input  logic       spiMosi,
	output spiRxByte_t rxByte,
	input  spiTxByte_t txByte,
	output logic       csActive,
	output logic       spiMiso
);

	// Quiet cycles after each byte pulse
	// Eight SCK periods per byte less a margin for sync jitter
	localparam int minByteGap = 14 * `SCK_HALF_MIN;

	// Oldest sample in bit 2
	logic [2:0] sckSync;
	logic [2:0] csSync;
	logic [2:0] mosiSync;
	logic       sckRise;
	logic       sckFall;
	// Bits received in the current byte
	logic [2:0] bitCnt;
	spiByte_t   rxShift;
	spiByte_t   txShift;
	spiByte_t   txHold;
	logic       txPending;

	// ------------------------------
	// Pin synchronisers
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			sckSync <= 3'b000;
			csSync  <= 3'b111;
		end
		else
		begin
			sckSync <= {sckSync[1:0], spiSck};
			csSync  <= {csSync[1:0], spiCsN};
		end
	end

	// Data line, qualified by SCK edges
	always_ff @(posedge iSysClk)
	begin
		mosiSync <= {mosiSync[1:0], spiMosi};
	end

	// Edges seen between stages 1 and 2
	assign sckRise  = sckSync[1] & ~sckSync[2];
	assign sckFall  = ~sckSync[1] & sckSync[2];
	assign csActive = ~csSync[2];

	// ------------------------------
	// Receive, MSB first
	// ------------------------------
	// MOSI taken from the sample just before the edge
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			bitCnt       <= '0;
			rxByte.valid <= 1'b0;
		end
		else
		begin
			rxByte.valid <= 1'b0;
			// Chip select high restarts byte alignment
			if (csSync[2])
				bitCnt <= '0;
			else if (sckRise)
			begin
				bitCnt  <= bitCnt + 3'd1;
				rxShift <= {rxShift[6:0], mosiSync[2]};
				// Bit 0 closes the byte
				if (bitCnt == 3'd7)
				begin
					rxByte.valid <= 1'b1;
					rxByte.data  <= {rxShift[6:0], mosiSync[2]};
				end
			end
		end
	end

	// ------------------------------
	// Transmit
	// ------------------------------
	// Offered byte waits here for the next falling edge
	always_ff @(posedge iSysClk)
	begin
		if (txByte.load)
			txHold <= txByte.data;
	end

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			txShift   <= `MISO_IDLE;
			txPending <= 1'b0;
		end
		else if (csSync[2])
		begin
			txShift   <= `MISO_IDLE;
			txPending <= 1'b0;
		end
		else
		begin
			if (txByte.load)
				txPending <= 1'b1;
			else if (sckFall)
				txPending <= 1'b0;
			if (sckFall)
			begin
				// Byte boundary: next MSB goes out
				if (bitCnt == 3'd0)
					txShift <= txPending ? txHold : `MISO_IDLE;
				else
					txShift <= {txShift[6:0], 1'b1};
			end
		end
	end

	assign spiMiso = txShift[7];

	// Byte pulses stay single and far apart at the fastest SCK
	rxValidPulse: assert property (@(posedge iSysClk) disable iff (rst)
		rxByte.valid |=> !rxByte.valid [*minByteGap]);

endmodule

//--- common/spiBridgePkg.sv
// Types for the SPI bridge; AXI4-Lite subset without prot, ids or bursts
`include "spiBridge_consts.svh"

package spiBridgePkg;

	// ------------------------------
	// Plain vectors
	// ------------------------------
	typedef logic [7:0] spiByte_t;
	typedef logic [31:0] csrAddr_t;
	typedef logic [31:0] csrData_t;

	// Frame command byte, anything else is unsupported
	typedef enum logic [7:0] {
		CmdCsrRead  = 8'd0,
		CmdCsrWrite = 8'd1
	} spiCmd_t;

	// Decoder states
	typedef enum logic [2:0] {
		StAddr,
		StCmd,
		StLen,
		StDummy,
		StData,
		StBusWr,
		StBusRd,
		StIgnore
	} frameState_t;

	// ------------------------------
	// Byte links
	// ------------------------------
	// One-cycle pulse per received byte
	typedef struct packed {
		logic     valid;
		spiByte_t data;
	} spiRxByte_t;

	// Next byte offered for MISO
	typedef struct packed {
		logic     load;
		spiByte_t data;
	} spiTxByte_t;

	// ------------------------------
	// AXI4-Lite
	// ------------------------------
	// Master driven
	typedef struct packed {
		logic                   awvalid;
		csrAddr_t               awaddr;
		logic                   wvalid;
		csrData_t               wdata;
		logic [`DATA_BYTES-1:0] wstrb;
		logic                   bready;
		logic                   arvalid;
		csrAddr_t               araddr;
		logic                   rready;
	} axiLiteReq_t;

	// Slave driven
	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		logic [1:0] bresp;
		logic       arready;
		logic       rvalid;
		csrData_t   rdata;
		logic [1:0] rresp;
	} axiLiteRsp_t;

endpackage

//--- common/spiBridge_consts.svh
// Sizes and fixed values shared by RTL and testbench; SCK half period below 4 clocks is unsupported
`ifndef SPIBRIDGE_CONSTS_SVH
`define SPIBRIDGE_CONSTS_SVH

// ------------------------------
// Register bank
// ------------------------------
// Number of 32-bit registers
`define CSR_COUNT 16
// Identifier word, register 0
`define CSR_ID_VALUE 32'h5B1D_0001

// ------------------------------
// Frame layout and SPI timing
// ------------------------------
// Address, command, length, dummy
`define HDR_BYTES 8
// Register access is always one word
`define DATA_BYTES 4
// Minimum SCK half period in system clocks
`define SCK_HALF_MIN 4
// Filler on MISO when nothing is loaded
`define MISO_IDLE 8'hFF

`endif
